// File: verilog/ecc_pkg.sv
package ecc_pkg;

    //////////////////////////////////////////////////////////////////////
    // field
    //////////////////////////////////////////////////////////////////////

    localparam int FE_W = 256;

    typedef logic [FE_W-1:0] fe_t;

    // SM2 prime
    localparam fe_t P_SM2 =
        256'hFFFFFFFE_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_00000000_FFFFFFFF_FFFFFFFF;

    // prime with one carry bit on top
    localparam logic [FE_W:0] P_EXT = {1'b0, P_SM2};

    typedef struct packed {
        fe_t x;
        fe_t y;
        fe_t z;
    } jac_point_t;

    //////////////////////////////////////////////////////////////////////
    // slot names
    //////////////////////////////////////////////////////////////////////

    typedef logic [4:0] slot_t;

    localparam int SLOT_COUNT = 25;

    localparam slot_t SLOT_X  = 5'd0;   // input point
    localparam slot_t SLOT_Y  = 5'd1;
    localparam slot_t SLOT_Z  = 5'd2;
    localparam slot_t S_ZZ    = 5'd3;
    localparam slot_t S_YY    = 5'd4;
    localparam slot_t S_XPZ   = 5'd5;
    localparam slot_t S_XMZ   = 5'd6;
    localparam slot_t S_XYY   = 5'd7;
    localparam slot_t S_Y4    = 5'd8;
    localparam slot_t S_2XYY  = 5'd9;
    localparam slot_t S_PROD  = 5'd10;
    localparam slot_t S_4XYY  = 5'd11;
    localparam slot_t S_YZ    = 5'd12;
    localparam slot_t S_2PROD = 5'd13;
    localparam slot_t S_M     = 5'd14;
    localparam slot_t S_MM    = 5'd15;
    localparam slot_t S_8XYY  = 5'd16;
    localparam slot_t S_X3    = 5'd17;
    localparam slot_t S_SMX   = 5'd18;
    localparam slot_t S_MSX   = 5'd19;
    localparam slot_t S_2Y4   = 5'd20;
    localparam slot_t S_4Y4   = 5'd21;
    localparam slot_t S_8Y4   = 5'd22;
    localparam slot_t S_Y3    = 5'd23;
    localparam slot_t S_Z3    = 5'd24;

    //////////////////////////////////////////////////////////////////////
    // unit operands and program steps
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        fe_t  a;
        fe_t  b;
        logic minus;    // a-b when set
    } unit_op_t;

    typedef struct packed {
        logic  use_mul;
        slot_t mul_a;
        slot_t mul_b;
        slot_t mul_dst;
        logic  use_add;
        logic  add_minus;
        slot_t add_a;
        slot_t add_b;
        slot_t add_dst;
    } step_t;

    localparam int DBL_STEPS = 15;

    typedef logic [3:0] step_idx_t;

endpackage

// File: verilog/fe_add_sub.sv
`timescale 1ns/10ps

module fe_add_sub (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  ecc_pkg::unit_op_t op,
    output ecc_pkg::fe_t      result,
    output logic              done
);
    import ecc_pkg::*;

    logic [FE_W:0] sum;
    logic [FE_W:0] sum_red;
    logic [FE_W:0] diff;
    logic [FE_W:0] diff_fix;

    // operands are below p, so one correction is enough
    always_comb begin
        sum  = {1'b0, op.a} + {1'b0, op.b};
        diff = {1'b0, op.a} - {1'b0, op.b};

        if (sum >= P_EXT) begin
            sum_red = sum - P_EXT;
        end else begin
            sum_red = sum;
        end

        if (diff[FE_W]) begin   // borrow out
            diff_fix = diff + P_EXT;
        end else begin
            diff_fix = diff;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (op.minus) begin
                result <= diff_fix[FE_W-1:0];
            end else begin
                result <= sum_red[FE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= start;  // single cycle latency
        end
    end

endmodule

// File: verilog/fe_mul.sv
`timescale 1ns/10ps

module fe_mul (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  ecc_pkg::unit_op_t op,
    output ecc_pkg::fe_t      result,
    output logic              done
);
    import ecc_pkg::*;

    logic          busy;
    logic [7:0]    bit_cnt;
    fe_t           a_reg;
    fe_t           b_sh;        // multiplier, msb first
    fe_t           acc;
    logic [FE_W:0] dbl;
    logic [FE_W:0] dbl_red;
    logic [FE_W:0] acc_sum;
    logic [FE_W:0] acc_red;

    //////////////////////////////////////////////////////////////////////
    // one scan step: acc = 2*acc (+ a) mod p
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dbl = {acc, 1'b0};
        if (dbl >= P_EXT) begin
            dbl_red = dbl - P_EXT;
        end else begin
            dbl_red = dbl;
        end

        if (b_sh[FE_W-1]) begin
            acc_sum = dbl_red + {1'b0, a_reg};
        end else begin
            acc_sum = dbl_red;
        end
        if (acc_sum >= P_EXT) begin
            acc_red = acc_sum - P_EXT;
        end else begin
            acc_red = acc_sum;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy && start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 8'd1;
                if (bit_cnt == 8'd255) begin    // last bit of b
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            a_reg <= op.a;
            b_sh  <= op.b;
            acc   <= '0;
        end else if (busy) begin
            b_sh <= {b_sh[FE_W-2:0], 1'b0};
            acc  <= acc_red[FE_W-1:0];
        end
    end

    assign result = acc;

endmodule

// File: verilog/slot_file.sv
`timescale 1ns/10ps

module slot_file (
    input  logic                clk,
    input  logic                rstn,
    input  logic                load,
    input  ecc_pkg::jac_point_t p_in,
    input  ecc_pkg::slot_t      mul_a_sel,
    input  ecc_pkg::slot_t      mul_b_sel,
    input  ecc_pkg::slot_t      add_a_sel,
    input  ecc_pkg::slot_t      add_b_sel,
    output ecc_pkg::fe_t        mul_a_val,
    output ecc_pkg::fe_t        mul_b_val,
    output ecc_pkg::fe_t        add_a_val,
    output ecc_pkg::fe_t        add_b_val,
    input  logic                mul_we,
    input  logic                add_we,
    input  ecc_pkg::slot_t      mul_dst,
    input  ecc_pkg::slot_t      add_dst,
    input  ecc_pkg::fe_t        mul_wdata,
    input  ecc_pkg::fe_t        add_wdata
);
    import ecc_pkg::*;

    fe_t slots [SLOT_COUNT];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < SLOT_COUNT; i++) begin
                slots[i] <= '0;
            end
        end else begin
            if (load) begin     // snapshot of the input point
                slots[SLOT_X] <= p_in.x;
                slots[SLOT_Y] <= p_in.y;
                slots[SLOT_Z] <= p_in.z;
            end
            if (mul_we) begin
                slots[mul_dst] <= mul_wdata;
            end
            if (add_we) begin
                slots[add_dst] <= add_wdata;
            end
        end
    end

    // combinational read ports
    assign mul_a_val = slots[mul_a_sel];
    assign mul_b_val = slots[mul_b_sel];
    assign add_a_val = slots[add_a_sel];
    assign add_b_val = slots[add_b_sel];

endmodule

// File: verilog/dbl_sequencer.sv
`timescale 1ns/10ps

module dbl_sequencer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    output logic                load,
    output ecc_pkg::slot_t      mul_a_sel,
    output ecc_pkg::slot_t      mul_b_sel,
    output ecc_pkg::slot_t      add_a_sel,
    output ecc_pkg::slot_t      add_b_sel,
    input  ecc_pkg::fe_t        mul_a_val,
    input  ecc_pkg::fe_t        mul_b_val,
    input  ecc_pkg::fe_t        add_a_val,
    input  ecc_pkg::fe_t        add_b_val,
    output logic                mul_start,
    output logic                add_start,
    output ecc_pkg::unit_op_t   mul_op,
    output ecc_pkg::unit_op_t   add_op,
    input  logic                mul_done,
    input  logic                add_done,
    input  ecc_pkg::fe_t        mul_result,
    input  ecc_pkg::fe_t        add_result,
    output logic                mul_we,
    output logic                add_we,
    output ecc_pkg::slot_t      mul_dst,
    output ecc_pkg::slot_t      add_dst,
    output ecc_pkg::fe_t        mul_wdata,
    output ecc_pkg::fe_t        add_wdata,
    output ecc_pkg::jac_point_t p_out,
    output logic                done
);
    import ecc_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT, ST_FINISH} state_t;

    state_t    state;
    step_idx_t step_idx;
    step_t     cur;
    logic      mul_pend;
    logic      add_pend;
    logic      step_clear;

    //////////////////////////////////////////////////////////////////////
    // doubling program
    //////////////////////////////////////////////////////////////////////

    // use_mul, mul_a, mul_b, mul_dst, use_add, minus, add_a, add_b, add_dst
    function automatic step_t prog_step(input step_idx_t idx);
        step_t s;
        case (idx)
            4'd0:  s = '{1'b1, SLOT_Z, SLOT_Z, S_ZZ, 1'b0, 1'b0, SLOT_X, SLOT_X, SLOT_X};
            4'd1:  s = '{1'b1, SLOT_Y, SLOT_Y, S_YY, 1'b1, 1'b0, SLOT_X, S_ZZ, S_XPZ};
            4'd2:  s = '{1'b1, SLOT_X, S_YY, S_XYY, 1'b1, 1'b1, SLOT_X, S_ZZ, S_XMZ};
            4'd3:  s = '{1'b1, S_YY, S_YY, S_Y4, 1'b1, 1'b0, S_XYY, S_XYY, S_2XYY};
            4'd4:  s = '{1'b1, S_XPZ, S_XMZ, S_PROD, 1'b1, 1'b0, S_2XYY, S_2XYY, S_4XYY};
            4'd5:  s = '{1'b1, SLOT_Y, SLOT_Z, S_YZ, 1'b1, 1'b0, S_PROD, S_PROD, S_2PROD};
            4'd6:  s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b0, S_PROD, S_2PROD, S_M};
            4'd7:  s = '{1'b1, S_M, S_M, S_MM, 1'b1, 1'b0, S_4XYY, S_4XYY, S_8XYY};
            4'd8:  s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b1, S_MM, S_8XYY, S_X3};
            4'd9:  s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b1, S_4XYY, S_X3, S_SMX};
            4'd10: s = '{1'b1, S_M, S_SMX, S_MSX, 1'b1, 1'b0, S_Y4, S_Y4, S_2Y4};
            4'd11: s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b0, S_2Y4, S_2Y4, S_4Y4};
            4'd12: s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b0, S_4Y4, S_4Y4, S_8Y4};
            4'd13: s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b1, S_MSX, S_8Y4, S_Y3};
            4'd14: s = '{1'b0, SLOT_X, SLOT_X, SLOT_X, 1'b1, 1'b0, S_YZ, S_YZ, S_Z3};
            default: s = '0;
        endcase
        return s;
    endfunction

    assign cur        = prog_step(step_idx);
    assign load       = (state == ST_IDLE) && start;
    assign step_clear = (!mul_pend || mul_done) && (!add_pend || add_done);

    // finish reads the result slots through the same ports
    always_comb begin
        if (state == ST_FINISH) begin
            mul_a_sel = S_X3;
            mul_b_sel = S_Y3;
            add_a_sel = S_Z3;
        end else begin
            mul_a_sel = cur.mul_a;
            mul_b_sel = cur.mul_b;
            add_a_sel = cur.add_a;
        end
    end
    assign add_b_sel = cur.add_b;

    assign mul_start = (state == ST_ISSUE) && cur.use_mul;
    assign add_start = (state == ST_ISSUE) && cur.use_add;
    assign mul_op    = '{a: mul_a_val, b: mul_b_val, minus: 1'b0};
    assign add_op    = '{a: add_a_val, b: add_b_val, minus: cur.add_minus};

    // write-back as each unit reports
    assign mul_we    = mul_done && mul_pend;
    assign add_we    = add_done && add_pend;
    assign mul_dst   = cur.mul_dst;
    assign add_dst   = cur.add_dst;
    assign mul_wdata = mul_result;
    assign add_wdata = add_result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            step_idx <= '0;
            mul_pend <= 1'b0;
            add_pend <= 1'b0;
            p_out    <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        step_idx <= '0;
                        state    <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    mul_pend <= cur.use_mul;
                    add_pend <= cur.use_add;
                    state    <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (mul_done) mul_pend <= 1'b0;
                    if (add_done) add_pend <= 1'b0;
                    if (step_clear) begin
                        if (step_idx == step_idx_t'(DBL_STEPS - 1)) begin
                            state <= ST_FINISH;
                        end else begin
                            step_idx <= step_idx + 4'd1;
                            state    <= ST_ISSUE;
                        end
                    end
                end
                default: begin  // ST_FINISH
                    p_out <= '{x: mul_a_val, y: mul_b_val, z: add_a_val};
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verilog/jac_point_double.sv
`timescale 1ns/10ps

module jac_point_double (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  ecc_pkg::jac_point_t p_in,
    output ecc_pkg::jac_point_t p_out,
    output logic                done
);
    import ecc_pkg::*;

    logic     load;
    slot_t    mul_a_sel;
    slot_t    mul_b_sel;
    slot_t    add_a_sel;
    slot_t    add_b_sel;
    fe_t      mul_a_val;
    fe_t      mul_b_val;
    fe_t      add_a_val;
    fe_t      add_b_val;
    logic     mul_start;
    logic     add_start;
    unit_op_t mul_op;
    unit_op_t add_op;
    logic     mul_done;
    logic     add_done;
    fe_t      mul_result;
    fe_t      add_result;
    logic     mul_we;
    logic     add_we;
    slot_t    mul_dst;
    slot_t    add_dst;
    fe_t      mul_wdata;
    fe_t      add_wdata;

    //////////////////////////////////////////////////////////////////////
    // control and storage
    //////////////////////////////////////////////////////////////////////

    dbl_sequencer seq_i (.*);

    slot_file slots_i (.*);

    //////////////////////////////////////////////////////////////////////
    // arithmetic units, run in parallel
    //////////////////////////////////////////////////////////////////////

    fe_mul mul_i (
        .clk    (clk),
        .rstn   (rstn),
        .start  (mul_start),
        .op     (mul_op),
        .result (mul_result),
        .done   (mul_done)
    );

    fe_add_sub addsub_i (
        .clk    (clk),
        .rstn   (rstn),
        .start  (add_start),
        .op     (add_op),
        .result (add_result),
        .done   (add_done)
    );

endmodule

// File: sim/dbl_sva.sv
`timescale 1ns/10ps

module dbl_sva (
    input logic clk,
    input logic rstn,
    input logic done,
    input logic mul_start,
    input logic add_start,
    input logic mul_pend,
    input logic add_pend
);

    int fail_cnt = 0;   // failed assertions so far

    // done is a one-cycle strobe
    done_single: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done stayed high for two cycles");
        end

    mul_no_reissue: assert property (@(posedge clk) disable iff (!rstn)
        mul_start |-> !mul_pend)
        else begin
            fail_cnt++;
            $error("multiplier started while a multiply was still pending");
        end

    add_no_reissue: assert property (@(posedge clk) disable iff (!rstn)
        add_start |-> !add_pend)
        else begin
            fail_cnt++;
            $error("adder started while an add was still pending");
        end

endmodule

// File: sim/dbl_checker.sv
`timescale 1ns/10ps

module dbl_checker (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  ecc_pkg::jac_point_t p_in,
    input  logic                done,
    input  ecc_pkg::jac_point_t p_out,
    output int                  tests_done,
    output int                  errors
);
    import ecc_pkg::*;

    string      test_name = "";     // written by the testbench per entry
    string      cur_name  = "";
    logic       busy      = 1'b0;
    jac_point_t expected  = '0;
    jac_point_t held      = '0;     // p_out as of the last done
    int         n_tests   = 0;
    int         n_err     = 0;

    assign tests_done = n_tests;
    assign errors     = n_err;

    //////////////////////////////////////////////////////////////////////
    // reference arithmetic, 512-bit then reduced
    //////////////////////////////////////////////////////////////////////

    function automatic fe_t mul_mod(input fe_t a, input fe_t b);
        logic [2*FE_W-1:0] w;
        w = {{FE_W{1'b0}}, a} * {{FE_W{1'b0}}, b};
        w = w % {{FE_W{1'b0}}, P_SM2};
        return w[FE_W-1:0];
    endfunction

    function automatic fe_t add_mod(input fe_t a, input fe_t b);
        logic [2*FE_W-1:0] w;
        w = ({{FE_W{1'b0}}, a} + {{FE_W{1'b0}}, b}) % {{FE_W{1'b0}}, P_SM2};
        return w[FE_W-1:0];
    endfunction

    function automatic fe_t sub_mod(input fe_t a, input fe_t b);
        logic [2*FE_W-1:0] w;
        w = {{FE_W{1'b0}}, a} + {{FE_W{1'b0}}, P_SM2} - {{FE_W{1'b0}}, b};
        w = w % {{FE_W{1'b0}}, P_SM2};
        return w[FE_W-1:0];
    endfunction

    // M=3(x-z^2)(x+z^2), S=4xy^2, x3=M^2-2S, y3=M(S-x3)-8y^4, z3=2yz
    function automatic jac_point_t ref_double(input jac_point_t pt);
        fe_t zz;
        fe_t yy;
        fe_t m;
        fe_t s;
        fe_t x3;
        fe_t y3;
        fe_t z3;
        zz = mul_mod(pt.z, pt.z);
        m  = mul_mod(fe_t'(3), mul_mod(sub_mod(pt.x, zz), add_mod(pt.x, zz)));
        yy = mul_mod(pt.y, pt.y);
        s  = mul_mod(fe_t'(4), mul_mod(pt.x, yy));
        x3 = sub_mod(mul_mod(m, m), mul_mod(fe_t'(2), s));
        y3 = sub_mod(mul_mod(m, sub_mod(s, x3)), mul_mod(fe_t'(8), mul_mod(yy, yy)));
        z3 = mul_mod(fe_t'(2), mul_mod(pt.y, pt.z));
        return '{x: x3, y: y3, z: z3};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            busy = 1'b0;
            held = '0;
        end else begin
            if (done) begin
                if (!busy) begin
                    n_err++;
                    $display("done pulsed with no doubling in progress");
                end else begin
                    n_tests++;
                    if (p_out !== expected) begin
                        n_err++;
                        $display("ERR %s expected %h actual %h", cur_name, expected, p_out);
                    end else begin
                        $display("ok  %s", cur_name);
                    end
                end
                busy = 1'b0;
                held = p_out;
            end else if (p_out !== held) begin
                n_err++;
                $display("p_out changed while no done was pulsed (%s)", cur_name);
                held = p_out;
            end
            if (start && !busy) begin   // idle design takes this one
                expected = ref_double(p_in);
                cur_name = test_name;
                busy     = 1'b1;
            end
        end
    end

endmodule

// File: sim/tb_jac_point_double.sv
`timescale 1ns/10ps

module tb_jac_point_double;
    import ecc_pkg::*;

    localparam int N_TESTS      = 7;
    localparam int DONE_TIMEOUT = 4000;     // a doubling takes about 2100 cycles

    logic        clk = 1'b0;
    logic        rstn;
    logic        start;
    jac_point_t  p_in;
    jac_point_t  p_out;
    logic        done;

    string       tab_name [N_TESTS];
    jac_point_t  tab_pt   [N_TESTS];
    int          tab_act  [N_TESTS];    // 0 plain, 1 extra start, 2 new p_in mid-run
    jac_point_t  alt_pt;
    int          tests_done;
    int          errors;
    int          timeouts = 0;
    int unsigned seed_val;

    always #4 clk = ~clk;

    jac_point_double dut_i (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .p_in  (p_in),
        .p_out (p_out),
        .done  (done)
    );

    dbl_checker checker_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .p_in       (p_in),
        .done       (done),
        .p_out      (p_out),
        .tests_done (tests_done),
        .errors     (errors)
    );

    bind dbl_sequencer dbl_sva sva_i (
        .clk       (clk),
        .rstn      (rstn),
        .done      (done),
        .mul_start (mul_start),
        .add_start (add_start),
        .mul_pend  (mul_pend),
        .add_pend  (add_pend)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    function automatic fe_t rand_fe();
        fe_t v;
        v = '0;
        for (int k = 0; k < 8; k++) begin
            v = {v[FE_W-33:0], $urandom()};
        end
        if (v >= P_SM2) begin   // one subtraction brings it below p
            v = v - P_SM2;
        end
        return v;
    endfunction

    task automatic build_table();
        fe_t gx;
        fe_t gy;
        gx = 256'h32C4AE2C_1F198119_5F990446_6A39C994_8FE30BBF_F2660BE1_715A4589_334C74C7;
        gy = 256'hBC3736A2_F4F6779C_59BDCEE3_6B692153_D0A9877C_C62A4740_02DF32E5_2139F0A0;
        tab_name[0] = "base_point";
        tab_pt[0]   = '{x: gx, y: gy, z: fe_t'(1)};
        tab_name[1] = "z_not_one";
        tab_pt[1]   = '{x: gy, y: gx,
                        z: 256'h01234567_89ABCDEF_FEDCBA98_76543210_0F1E2D3C_4B5A6978_8796A5B4_C3D2E1F0};
        tab_name[2] = "y_zero";
        tab_pt[2]   = '{x: gx, y: '0, z: fe_t'(7)};
        tab_name[3] = "all_p_minus_1";
        tab_pt[3]   = '{x: P_SM2 - 1, y: P_SM2 - 1, z: P_SM2 - 1};
        tab_name[4] = "random_0";
        tab_name[5] = "random_1_start_busy";
        tab_name[6] = "random_2_pin_change";
        for (int k = 4; k < N_TESTS; k++) begin
            tab_pt[k] = '{x: rand_fe(), y: rand_fe(), z: rand_fe()};
        end
        for (int k = 0; k < N_TESTS; k++) begin
            tab_act[k] = (k >= 5) ? k - 4 : 0;
        end
        alt_pt = '{x: rand_fe(), y: rand_fe(), z: rand_fe()};
    endtask

    task automatic run_one(input int idx);
        int cycles;
        @(posedge clk);
        checker_i.test_name = tab_name[idx];
        start <= 1'b1;
        p_in  <= tab_pt[idx];
        @(posedge clk);
        start <= 1'b0;
        if (tab_act[idx] != 0) begin    // disturb the running doubling
            repeat (20) @(posedge clk);
            p_in  <= alt_pt;
            start <= (tab_act[idx] == 1);
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            timeouts++;
            $display("timeout: test %s got no done within %0d cycles",
                     tab_name[idx], DONE_TIMEOUT);
        end
    endtask

    task automatic finish_run();
        logic failed;
        int   sva_fails;
        sva_fails = dut_i.seq_i.sva_i.fail_cnt;
        failed    = (errors != 0) || (timeouts != 0) || (tests_done != N_TESTS)
                    || (sva_fails != 0);
        if (timeouts == 0 && tests_done != N_TESTS) begin
            $display("checker saw %0d results for %0d tests", tests_done, N_TESTS);
        end
        if (sva_fails != 0) begin
            $display("%0d assertion failures in the sequencer", sva_fails);
        end
        $display("tests %0d, errors %0d, timeouts %0d", tests_done, errors, timeouts);
        if (failed) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    endtask

    initial begin
        seed_val = $urandom(11);
        rstn  <= 1'b0;
        start <= 1'b0;
        p_in  <= '0;
        build_table();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);  // idle cycles, checker sees p_out stay zero
        for (int i = 0; i < N_TESTS && timeouts == 0; i++) begin
            run_one(i);
        end
        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

// File: jac_point_double.f
verilog/ecc_pkg.sv
verilog/fe_add_sub.sv
verilog/fe_mul.sv
verilog/slot_file.sv
verilog/dbl_sequencer.sv
verilog/jac_point_double.sv
sim/dbl_sva.sv
sim/dbl_checker.sv
sim/tb_jac_point_double.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_jac_point_double \
		-f jac_point_double.f -Mdir obj_dir
	./obj_dir/Vtb_jac_point_double > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
